// File: src/mem_types_pkg.sv
package mem_types_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int DATA_W      = 32;
	localparam int BYTE_ADDR_W = 16;
	localparam int WORD_ADDR_W = BYTE_ADDR_W - 2;
	localparam int EXC_W       = 4;

	// --------------------------------------------------
	// data formats
	// --------------------------------------------------
	typedef logic [DATA_W-1:0]      data_t;
	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
	// byte address without its low two bits
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;
	typedef logic [EXC_W-1:0]       exc_t;

	// sticky exception bit positions
	localparam int EXC_INST_ALIGN = 0;
	localparam int EXC_DATA_ALIGN = 1;
	localparam int EXC_READ_RESP  = 2;
	localparam int EXC_WRITE_RESP = 3;

endpackage

// File: src/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

	// who holds the shared memory link
	typedef enum logic {OWNER_INST, OWNER_DATA} owner_e;

	// --------------------------------------------------
	// state machines
	// --------------------------------------------------
	typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_e;

	typedef enum logic [1:0] {C_IDLE, C_RESP, C_WAIT_MEM} cache_state_e;

	typedef enum logic [2:0] {
		AX_IDLE, AX_READ_ADDR, AX_READ_DATA, AX_WRITE, AX_WRITE_RESP
	} axi_state_e;

	// axi response codes
	typedef logic [1:0] axi_resp_t;
	localparam axi_resp_t RESP_OKAY   = 2'd0;
	localparam axi_resp_t RESP_SLVERR = 2'd2;

endpackage

// File: src/mem_link_if.sv
`timescale 1ns/10ps

interface mem_link_if;

	// request side
	logic                      req;
	logic                      we;
	mem_types_pkg::word_addr_t addr;
	mem_types_pkg::data_t      wdata;

	// response side, valid together with done
	mem_types_pkg::data_t      rdata;
	logic                      err;
	logic                      done;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  rdata,
		input  err,
		input  done
	);

	modport responder (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output rdata,
		output err,
		output done
	);

endinterface

// File: src/l1_word_cache.sv
`timescale 1ns/10ps

module l1_word_cache #(
	parameter int LINES = 16
) (
	input  logic                      clock_cntrl_i,
	input  logic                      reset_i,
	input  logic                      core_req_i,
	input  logic                      core_we_i,
	input  mem_types_pkg::byte_addr_t core_addr_i,
	input  mem_types_pkg::data_t      core_wdata_i,
	output mem_types_pkg::data_t      core_rdata_o,
	output logic                      core_done_o,
	output logic                      misaligned_o,
	mem_link_if.requester             link
);

	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = mem_types_pkg::WORD_ADDR_W - IDX_W;

	mem_ctrl_pkg::cache_state_e state_q;
	logic [LINES-1:0]           valid_q;
	logic [TAG_W-1:0]           tag_q [LINES];
	mem_types_pkg::data_t       line_q [LINES];

	mem_types_pkg::word_addr_t  core_word;
	logic [IDX_W-1:0]           core_idx;
	logic [TAG_W-1:0]           core_tag;
	logic                       aligned;
	logic                       hit;
	logic                       accept;
	logic                       accept_local;
	logic                       mem_done;

	// request held for the link
	mem_types_pkg::word_addr_t  req_addr_q;
	logic                       req_we_q;
	mem_types_pkg::data_t       req_wdata_q;
	logic [IDX_W-1:0]           req_idx;
	logic [TAG_W-1:0]           req_tag;

	mem_types_pkg::data_t       rdata_q;
	logic                       misaligned_q;

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------
	assign core_word = core_addr_i[mem_types_pkg::BYTE_ADDR_W-1:2];
	assign core_idx  = core_word[IDX_W-1:0];
	assign core_tag  = core_word[mem_types_pkg::WORD_ADDR_W-1:IDX_W];
	assign aligned   = (core_addr_i[1:0] == 2'b00);
	assign hit       = valid_q[core_idx] && (tag_q[core_idx] == core_tag);

	assign accept       = (state_q == mem_ctrl_pkg::C_IDLE) && core_req_i;
	// answered without the link
	assign accept_local = !aligned || (!core_we_i && hit);
	assign mem_done     = (state_q == mem_ctrl_pkg::C_WAIT_MEM) && link.done;

	assign req_idx = req_addr_q[IDX_W-1:0];
	assign req_tag = req_addr_q[mem_types_pkg::WORD_ADDR_W-1:IDX_W];

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			state_q      <= mem_ctrl_pkg::C_IDLE;
			valid_q      <= '0;
			misaligned_q <= 1'b0;
		end else begin
			misaligned_q <= accept && !aligned;
			case (state_q)
				mem_ctrl_pkg::C_IDLE: begin
					if (accept && accept_local)
						state_q <= mem_ctrl_pkg::C_RESP;
					else if (accept)
						state_q <= mem_ctrl_pkg::C_WAIT_MEM;
				end
				mem_ctrl_pkg::C_WAIT_MEM: begin
					if (link.done) begin
						state_q <= mem_ctrl_pkg::C_RESP;
						// a write allocates and a failed write drops the line
						if (req_we_q)
							valid_q[req_idx] <= !link.err;
						else if (!link.err)
							valid_q[req_idx] <= 1'b1;
					end
				end
				// done is high here while req is still up
				mem_ctrl_pkg::C_RESP: state_q <= mem_ctrl_pkg::C_IDLE;
				default: state_q <= mem_ctrl_pkg::C_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// tags, lines and request payload
	// --------------------------------------------------
	always_ff @(posedge clock_cntrl_i) begin
		if (accept) begin
			req_addr_q  <= core_word;
			req_we_q    <= core_we_i;
			req_wdata_q <= core_wdata_i;
			rdata_q     <= (aligned && hit && !core_we_i) ? line_q[core_idx] : '0;
		end
		if (mem_done) begin
			if (req_we_q) begin
				tag_q[req_idx]  <= req_tag;
				line_q[req_idx] <= req_wdata_q;
				rdata_q         <= '0;
			end else begin
				if (!link.err) begin
					tag_q[req_idx]  <= req_tag;
					line_q[req_idx] <= link.rdata;
				end
				rdata_q <= link.err ? '0 : link.rdata;
			end
		end
	end

	assign link.req   = (state_q == mem_ctrl_pkg::C_WAIT_MEM);
	assign link.we    = req_we_q;
	assign link.addr  = req_addr_q;
	assign link.wdata = req_wdata_q;

	assign core_rdata_o = rdata_q;
	assign core_done_o  = (state_q == mem_ctrl_pkg::C_RESP);
	assign misaligned_o = misaligned_q;

	// the link answers only a request that is still outstanding
	a_done_outstanding: assert property (@(posedge clock_cntrl_i) disable iff (!reset_i)
		link.done |-> (state_q == mem_ctrl_pkg::C_WAIT_MEM));

endmodule

// File: src/access_arbiter.sv
`timescale 1ns/10ps

module access_arbiter (
	input  logic                clock_cntrl_i,
	input  logic                reset_i,
	mem_link_if.responder       inst_link,
	mem_link_if.responder       data_link,
	mem_link_if.requester       mem_link,
	input  logic                inst_misaligned_i,
	input  logic                data_misaligned_i,
	output mem_types_pkg::exc_t exceptions_o
);

	mem_ctrl_pkg::arb_state_e state_q;
	mem_ctrl_pkg::owner_e     owner_q;
	mem_types_pkg::exc_t      exc_q;

	logic busy;
	logic inst_owns;
	logic data_owns;

	assign busy      = (state_q == mem_ctrl_pkg::ARB_BUSY);
	assign inst_owns = busy && (owner_q == mem_ctrl_pkg::OWNER_INST);
	assign data_owns = busy && (owner_q == mem_ctrl_pkg::OWNER_DATA);

	// --------------------------------------------------
	// ownership
	// --------------------------------------------------
	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			state_q <= mem_ctrl_pkg::ARB_IDLE;
			owner_q <= mem_ctrl_pkg::OWNER_INST;
		end else begin
			case (state_q)
				mem_ctrl_pkg::ARB_IDLE: begin
					// instruction side first
					if (inst_link.req) begin
						owner_q <= mem_ctrl_pkg::OWNER_INST;
						state_q <= mem_ctrl_pkg::ARB_BUSY;
					end else if (data_link.req) begin
						owner_q <= mem_ctrl_pkg::OWNER_DATA;
						state_q <= mem_ctrl_pkg::ARB_BUSY;
					end
				end
				mem_ctrl_pkg::ARB_BUSY: begin
					if (mem_link.done)
						state_q <= mem_ctrl_pkg::ARB_IDLE;
				end
				default: state_q <= mem_ctrl_pkg::ARB_IDLE;
			endcase
		end
	end

	// owner's request onto the shared link
	assign mem_link.req   = inst_owns ? inst_link.req : (data_owns && data_link.req);
	assign mem_link.we    = (owner_q == mem_ctrl_pkg::OWNER_INST) ? inst_link.we : data_link.we;
	assign mem_link.addr  = (owner_q == mem_ctrl_pkg::OWNER_INST) ? inst_link.addr
		: data_link.addr;
	assign mem_link.wdata = (owner_q == mem_ctrl_pkg::OWNER_INST) ? inst_link.wdata
		: data_link.wdata;

	// response goes back to the owner only
	assign inst_link.done  = inst_owns && mem_link.done;
	assign inst_link.err   = inst_owns && mem_link.err;
	assign inst_link.rdata = inst_owns ? mem_link.rdata : '0;
	assign data_link.done  = data_owns && mem_link.done;
	assign data_link.err   = data_owns && mem_link.err;
	assign data_link.rdata = data_owns ? mem_link.rdata : '0;

	// --------------------------------------------------
	// sticky exceptions
	// --------------------------------------------------
	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			exc_q <= '0;
		end else begin
			if (inst_misaligned_i)
				exc_q[mem_types_pkg::EXC_INST_ALIGN] <= 1'b1;
			if (data_misaligned_i)
				exc_q[mem_types_pkg::EXC_DATA_ALIGN] <= 1'b1;
			if (mem_link.done && mem_link.err) begin
				if (mem_link.we)
					exc_q[mem_types_pkg::EXC_WRITE_RESP] <= 1'b1;
				else
					exc_q[mem_types_pkg::EXC_READ_RESP] <= 1'b1;
			end
		end
	end

	assign exceptions_o = exc_q;

	// the owner keeps its request up until done and is not handed over
	a_owner_hold: assert property (@(posedge clock_cntrl_i) disable iff (!reset_i)
		mem_link.req && !mem_link.done |=> mem_link.req && $stable(owner_q));

endmodule

// File: src/axi_lite_master.sv
`timescale 1ns/10ps

module axi_lite_master (
	input  logic                      clock_cntrl_i,
	input  logic                      reset_i,
	mem_link_if.responder             link,
	// write address and data
	output mem_types_pkg::byte_addr_t awaddr_o,
	output logic                      awvalid_o,
	input  logic                      awready_i,
	output mem_types_pkg::data_t      wdata_o,
	output logic [3:0]                wstrb_o,
	output logic                      wvalid_o,
	input  logic                      wready_i,
	// write response
	input  mem_ctrl_pkg::axi_resp_t   bresp_i,
	input  logic                      bvalid_i,
	output logic                      bready_o,
	// read
	output mem_types_pkg::byte_addr_t araddr_o,
	output logic                      arvalid_o,
	input  logic                      arready_i,
	input  mem_types_pkg::data_t      rdata_i,
	input  mem_ctrl_pkg::axi_resp_t   rresp_i,
	input  logic                      rvalid_i,
	output logic                      rready_o
);

	mem_ctrl_pkg::axi_state_e  state_q;
	logic                      awvalid_q;
	logic                      wvalid_q;
	logic                      arvalid_q;
	logic                      done_q;
	logic                      aw_clear;
	logic                      w_clear;

	mem_types_pkg::byte_addr_t addr_q;
	mem_types_pkg::data_t      wdata_q;
	mem_types_pkg::data_t      rdata_q;
	logic                      err_q;

	// each channel is finished once its valid is gone or accepted now
	assign aw_clear = !awvalid_q || awready_i;
	assign w_clear  = !wvalid_q || wready_i;

	// --------------------------------------------------
	// transaction FSM
	// --------------------------------------------------
	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			state_q   <= mem_ctrl_pkg::AX_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			arvalid_q <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				mem_ctrl_pkg::AX_IDLE: begin
					// skip the cycle in which done is still up
					if (link.req && !done_q) begin
						if (link.we) begin
							awvalid_q <= 1'b1;
							wvalid_q  <= 1'b1;
							state_q   <= mem_ctrl_pkg::AX_WRITE;
						end else begin
							arvalid_q <= 1'b1;
							state_q   <= mem_ctrl_pkg::AX_READ_ADDR;
						end
					end
				end
				mem_ctrl_pkg::AX_READ_ADDR: begin
					if (arready_i) begin
						arvalid_q <= 1'b0;
						state_q   <= mem_ctrl_pkg::AX_READ_DATA;
					end
				end
				mem_ctrl_pkg::AX_READ_DATA: begin
					if (rvalid_i) begin
						done_q  <= 1'b1;
						state_q <= mem_ctrl_pkg::AX_IDLE;
					end
				end
				mem_ctrl_pkg::AX_WRITE: begin
					if (awready_i)
						awvalid_q <= 1'b0;
					if (wready_i)
						wvalid_q <= 1'b0;
					if (aw_clear && w_clear)
						state_q <= mem_ctrl_pkg::AX_WRITE_RESP;
				end
				mem_ctrl_pkg::AX_WRITE_RESP: begin
					if (bvalid_i) begin
						done_q  <= 1'b1;
						state_q <= mem_ctrl_pkg::AX_IDLE;
					end
				end
				default: state_q <= mem_ctrl_pkg::AX_IDLE;
			endcase
		end
	end

	// payload capture
	always_ff @(posedge clock_cntrl_i) begin
		if (state_q == mem_ctrl_pkg::AX_IDLE && link.req && !done_q) begin
			addr_q  <= {link.addr, 2'b00};
			wdata_q <= link.wdata;
		end
		if (state_q == mem_ctrl_pkg::AX_READ_DATA && rvalid_i) begin
			rdata_q <= rdata_i;
			err_q   <= (rresp_i != mem_ctrl_pkg::RESP_OKAY);
		end
		if (state_q == mem_ctrl_pkg::AX_WRITE_RESP && bvalid_i) begin
			rdata_q <= '0;
			err_q   <= (bresp_i != mem_ctrl_pkg::RESP_OKAY);
		end
	end

	assign awaddr_o  = addr_q;
	assign awvalid_o = awvalid_q;
	assign wdata_o   = wdata_q;
	assign wstrb_o   = 4'hf;
	assign wvalid_o  = wvalid_q;
	assign bready_o  = (state_q == mem_ctrl_pkg::AX_WRITE_RESP);
	assign araddr_o  = addr_q;
	assign arvalid_o = arvalid_q;
	assign rready_o  = (state_q == mem_ctrl_pkg::AX_READ_DATA);

	assign link.done  = done_q;
	assign link.rdata = rdata_q;
	assign link.err   = err_q;

	// a stalled write address is held and belongs to the request on the link
	a_awaddr_stable: assert property (@(posedge clock_cntrl_i) disable iff (!reset_i)
		awvalid_o && !awready_i |=> $stable(awaddr_o) && (awaddr_o == {link.addr, 2'b00}));

endmodule

// File: src/mem_subsystem_top.sv
`timescale 1ns/10ps

module mem_subsystem_top #(
	// line counts, powers of two
	parameter int INST_LINES = 16,
	parameter int DATA_LINES = 16
) (
	input  logic                      clock_cntrl_i,
	input  logic                      reset_i,
	// instruction port
	input  logic                      inst_req_i,
	input  logic                      inst_we_i,
	input  mem_types_pkg::byte_addr_t inst_addr_i,
	input  mem_types_pkg::data_t      inst_wdata_i,
	output mem_types_pkg::data_t      inst_rdata_o,
	output logic                      inst_done_o,
	// data port
	input  logic                      data_req_i,
	input  logic                      data_we_i,
	input  mem_types_pkg::byte_addr_t data_addr_i,
	input  mem_types_pkg::data_t      data_wdata_i,
	output mem_types_pkg::data_t      data_rdata_o,
	output logic                      data_done_o,
	// axi4-lite
	output mem_types_pkg::byte_addr_t awaddr_o,
	output logic                      awvalid_o,
	input  logic                      awready_i,
	output mem_types_pkg::data_t      wdata_o,
	output logic [3:0]                wstrb_o,
	output logic                      wvalid_o,
	input  logic                      wready_i,
	input  mem_ctrl_pkg::axi_resp_t   bresp_i,
	input  logic                      bvalid_i,
	output logic                      bready_o,
	output mem_types_pkg::byte_addr_t araddr_o,
	output logic                      arvalid_o,
	input  logic                      arready_i,
	input  mem_types_pkg::data_t      rdata_i,
	input  mem_ctrl_pkg::axi_resp_t   rresp_i,
	input  logic                      rvalid_i,
	output logic                      rready_o,
	output mem_types_pkg::exc_t       exceptions_o
);

	logic inst_misaligned;
	logic data_misaligned;

	mem_link_if inst_link ();
	mem_link_if data_link ();
	mem_link_if mem_link ();

	// --------------------------------------------------
	// L1 caches
	// --------------------------------------------------
	l1_word_cache #(.LINES(INST_LINES)) inst_cache (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.core_req_i(inst_req_i), .core_we_i(inst_we_i),
		.core_addr_i(inst_addr_i), .core_wdata_i(inst_wdata_i),
		.core_rdata_o(inst_rdata_o), .core_done_o(inst_done_o),
		.misaligned_o(inst_misaligned), .link(inst_link.requester)
	);

	l1_word_cache #(.LINES(DATA_LINES)) data_cache (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.core_req_i(data_req_i), .core_we_i(data_we_i),
		.core_addr_i(data_addr_i), .core_wdata_i(data_wdata_i),
		.core_rdata_o(data_rdata_o), .core_done_o(data_done_o),
		.misaligned_o(data_misaligned), .link(data_link.requester)
	);

	// shared path to memory
	access_arbiter arbiter (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.inst_link(inst_link.responder), .data_link(data_link.responder),
		.mem_link(mem_link.requester),
		.inst_misaligned_i(inst_misaligned), .data_misaligned_i(data_misaligned),
		.exceptions_o(exceptions_o)
	);

	axi_lite_master axi_master (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.link(mem_link.responder),
		.awaddr_o(awaddr_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
		.wdata_o(wdata_o), .wstrb_o(wstrb_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
		.bresp_i(bresp_i), .bvalid_i(bvalid_i), .bready_o(bready_o),
		.araddr_o(araddr_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
		.rdata_i(rdata_i), .rresp_i(rresp_i), .rvalid_i(rvalid_i), .rready_o(rready_o)
	);

endmodule

// File: tb/axi_lite_mem_model.sv
`timescale 1ns/10ps

module axi_lite_mem_model (
	input  logic                      clock_cntrl_i,
	input  logic                      reset_i,
	input  mem_types_pkg::byte_addr_t awaddr_i,
	input  logic                      awvalid_i,
	output logic                      awready_o,
	input  mem_types_pkg::data_t      wdata_i,
	input  logic                      wvalid_i,
	output logic                      wready_o,
	output mem_ctrl_pkg::axi_resp_t   bresp_o,
	output logic                      bvalid_o,
	input  logic                      bready_i,
	input  mem_types_pkg::byte_addr_t araddr_i,
	input  logic                      arvalid_i,
	output logic                      arready_o,
	output mem_types_pkg::data_t      rdata_o,
	output mem_ctrl_pkg::axi_resp_t   rresp_o,
	output logic                      rvalid_o,
	input  logic                      rready_i
);

	localparam int WORDS = 2 ** mem_types_pkg::WORD_ADDR_W;

	mem_types_pkg::data_t      mem [WORDS];
	mem_types_pkg::byte_addr_t aw_addr_q;
	mem_types_pkg::data_t      w_data_q;
	logic                      aw_have_q;
	logic                      w_have_q;
	logic [1:0]                aw_wait_q;
	logic [1:0]                w_wait_q;
	logic [1:0]                ar_wait_q;

	// every word starts out as a pattern of its own word address
	initial begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = {2'b10, 14'(i), 2'b01, 14'(i)};
		awready_o = 1'b0;
		wready_o  = 1'b0;
		arready_o = 1'b0;
		bvalid_o  = 1'b0;
		rvalid_o  = 1'b0;
		bresp_o   = mem_ctrl_pkg::RESP_OKAY;
		rresp_o   = mem_ctrl_pkg::RESP_OKAY;
		rdata_o   = '0;
	end

	always @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			awready_o <= 1'b0;
			wready_o  <= 1'b0;
			arready_o <= 1'b0;
			bvalid_o  <= 1'b0;
			rvalid_o  <= 1'b0;
			aw_have_q <= 1'b0;
			w_have_q  <= 1'b0;
			aw_wait_q <= '0;
			w_wait_q  <= '0;
			ar_wait_q <= '0;
		end else begin
			// --------------------------------------------------
			// write address and data, each with its own delay
			// --------------------------------------------------
			if (awready_o && awvalid_i) begin
				awready_o <= 1'b0;
				aw_have_q <= 1'b1;
				aw_addr_q <= awaddr_i;
				aw_wait_q <= 2'($urandom % 4);
			end else if (awvalid_i && !aw_have_q && !awready_o) begin
				if (aw_wait_q == 0)
					awready_o <= 1'b1;
				else
					aw_wait_q <= aw_wait_q - 2'd1;
			end
			if (wready_o && wvalid_i) begin
				wready_o <= 1'b0;
				w_have_q <= 1'b1;
				w_data_q <= wdata_i;
				w_wait_q <= 2'($urandom % 4);
			end else if (wvalid_i && !w_have_q && !wready_o) begin
				if (w_wait_q == 0)
					wready_o <= 1'b1;
				else
					w_wait_q <= w_wait_q - 2'd1;
			end
			// write response, upper half of the space answers SLVERR
			if (bvalid_o && bready_i) begin
				bvalid_o  <= 1'b0;
				aw_have_q <= 1'b0;
				w_have_q  <= 1'b0;
			end else if (aw_have_q && w_have_q && !bvalid_o) begin
				bvalid_o <= 1'b1;
				if (aw_addr_q[15]) begin
					bresp_o <= mem_ctrl_pkg::RESP_SLVERR;
				end else begin
					bresp_o <= mem_ctrl_pkg::RESP_OKAY;
					mem[aw_addr_q[15:2]] <= w_data_q;
				end
			end
			// --------------------------------------------------
			// read
			// --------------------------------------------------
			if (rvalid_o && rready_i)
				rvalid_o <= 1'b0;
			if (arready_o && arvalid_i) begin
				arready_o <= 1'b0;
				ar_wait_q <= 2'($urandom % 4);
				rvalid_o  <= 1'b1;
				rdata_o   <= araddr_i[15] ? '0 : mem[araddr_i[15:2]];
				rresp_o   <= araddr_i[15] ? mem_ctrl_pkg::RESP_SLVERR : mem_ctrl_pkg::RESP_OKAY;
			end else if (arvalid_i && !arready_o && !rvalid_o) begin
				if (ar_wait_q == 0)
					arready_o <= 1'b1;
				else
					ar_wait_q <= ar_wait_q - 2'd1;
			end
		end
	end

endmodule

// File: tb/tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem;

	localparam int LINES   = 16;
	localparam int TIMEOUT = 200;

	logic                      clock_cntrl_i;
	logic                      reset_i;
	logic                      inst_req_i;
	logic                      inst_we_i;
	mem_types_pkg::byte_addr_t inst_addr_i;
	mem_types_pkg::data_t      inst_wdata_i;
	mem_types_pkg::data_t      inst_rdata_o;
	logic                      inst_done_o;
	logic                      data_req_i;
	logic                      data_we_i;
	mem_types_pkg::byte_addr_t data_addr_i;
	mem_types_pkg::data_t      data_wdata_i;
	mem_types_pkg::data_t      data_rdata_o;
	logic                      data_done_o;
	mem_types_pkg::byte_addr_t awaddr_o;
	logic                      awvalid_o;
	logic                      awready_i;
	mem_types_pkg::data_t      wdata_o;
	logic [3:0]                wstrb_o;
	logic                      wvalid_o;
	logic                      wready_i;
	mem_ctrl_pkg::axi_resp_t   bresp_i;
	logic                      bvalid_i;
	logic                      bready_o;
	mem_types_pkg::byte_addr_t araddr_o;
	logic                      arvalid_o;
	logic                      arready_i;
	mem_types_pkg::data_t      rdata_i;
	mem_ctrl_pkg::axi_resp_t   rresp_i;
	logic                      rvalid_i;
	logic                      rready_o;
	mem_types_pkg::exc_t       exceptions_o;

	// reference model with a word memory and one tag/valid array per cache
	mem_types_pkg::data_t      ref_mem [2 ** mem_types_pkg::WORD_ADDR_W];
	mem_types_pkg::word_addr_t line_addr [2][LINES];
	logic                      line_valid [2][LINES];

	int                        errors = 0;
	int                        checks = 0;
	int                        aw_count = 0;
	int                        w_count = 0;
	mem_types_pkg::byte_addr_t ar_log [$];
	mem_types_pkg::byte_addr_t last_awaddr;
	mem_types_pkg::data_t      last_wdata;
	logic [3:0]                last_wstrb;

	mem_subsystem_top #(.INST_LINES(LINES), .DATA_LINES(LINES)) uut (.*);

	axi_lite_mem_model memory (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.awaddr_i(awaddr_o), .awvalid_i(awvalid_o), .awready_o(awready_i),
		.wdata_i(wdata_o), .wvalid_i(wvalid_o), .wready_o(wready_i),
		.bresp_o(bresp_i), .bvalid_o(bvalid_i), .bready_i(bready_o),
		.araddr_i(araddr_o), .arvalid_i(arvalid_o), .arready_o(arready_i),
		.rdata_o(rdata_i), .rresp_o(rresp_i), .rvalid_o(rvalid_i), .rready_i(rready_o)
	);

	initial begin
		clock_cntrl_i = 1'b0;
		forever #20 clock_cntrl_i = ~clock_cntrl_i;
	end

	// axi handshakes seen at the top ports
	always @(posedge clock_cntrl_i) begin
		if (awvalid_o && awready_i) begin
			aw_count++;
			last_awaddr = awaddr_o;
		end
		if (wvalid_o && wready_i) begin
			w_count++;
			last_wdata = wdata_o;
			last_wstrb = wstrb_o;
		end
		if (arvalid_o && arready_i)
			ar_log.push_back(araddr_o);
	end

	// --------------------------------------------------
	// checking and ending the run
	// --------------------------------------------------
	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	task automatic give_up(input string what);
		errors++;
		$display("timeout: %s never came", what);
		finish_run();
	endtask

	task automatic drive_port(input logic port, input logic req, input logic we,
			input mem_types_pkg::byte_addr_t addr, input mem_types_pkg::data_t wdata);
		if (port) begin
			data_req_i   = req;
			data_we_i    = we;
			data_addr_i  = addr;
			data_wdata_i = wdata;
		end else begin
			inst_req_i   = req;
			inst_we_i    = we;
			inst_addr_i  = addr;
			inst_wdata_i = wdata;
		end
	endtask

	// one core access; strict adds the AXI side checks
	task automatic access(input logic port, input logic we, input mem_types_pkg::byte_addr_t addr,
			input mem_types_pkg::data_t wdata, input logic strict);
		mem_types_pkg::word_addr_t wa;
		mem_types_pkg::data_t      exp;
		mem_types_pkg::data_t      got;
		int                        idx;
		int                        cycles;
		int                        ar0;
		int                        aw0;
		int                        w0;
		int                        exc_bit;
		logic                      bad;
		logic                      err;
		logic                      hit;
		logic                      done;
		string                     tag;
		wa   = addr[15:2];
		idx  = int'(wa) % LINES;
		bad  = (addr[1:0] != 2'b00);
		err  = addr[15];
		hit  = line_valid[port][idx] && (line_addr[port][idx] == wa);
		exp  = (bad || err || we) ? '0 : ref_mem[wa];
		tag  = port ? "data" : "inst";
		ar0  = ar_log.size();
		aw0  = aw_count;
		w0   = w_count;
		// write allocates and a failed write drops the line; a good read miss fills it
		if (!bad && we) begin
			line_valid[port][idx] = !err;
			line_addr[port][idx]  = wa;
			if (!err)
				ref_mem[wa] = wdata;
		end else if (!bad && !hit && !err) begin
			line_valid[port][idx] = 1'b1;
			line_addr[port][idx]  = wa;
		end
		drive_port(port, 1'b1, we, addr, wdata);
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			@(negedge clock_cntrl_i);
			cycles++;
			done = port ? data_done_o : inst_done_o;
			got  = port ? data_rdata_o : inst_rdata_o;
			if (!done && cycles > TIMEOUT)
				give_up({tag, "_done_o"});
		end
		if (!we || bad)
			check_eq({tag, "_rdata_o"}, got, exp);
		@(negedge clock_cntrl_i);
		drive_port(port, 1'b0, 1'b0, '0, '0);
		check_eq({tag, "_done_o"}, port ? data_done_o : inst_done_o, 0);
		if (bad) begin
			exc_bit = port ? mem_types_pkg::EXC_DATA_ALIGN : mem_types_pkg::EXC_INST_ALIGN;
			check_eq("exceptions_o align bit", exceptions_o[exc_bit], 1);
		end else if (err) begin
			exc_bit = we ? mem_types_pkg::EXC_WRITE_RESP : mem_types_pkg::EXC_READ_RESP;
			check_eq("exceptions_o resp bit", exceptions_o[exc_bit], 1);
		end
		if (strict) begin
			if (bad || (!we && hit)) begin
				check_eq("done latency", cycles, 1);
				check_eq("ar handshakes", ar_log.size() - ar0, 0);
			end else if (!we) begin
				check_eq("ar handshakes", ar_log.size() - ar0, 1);
				if (ar_log.size() > ar0)
					check_eq("araddr_o", ar_log[ar0], addr);
			end
			if (we && !bad) begin
				check_eq("aw handshakes", aw_count - aw0, 1);
				check_eq("w handshakes", w_count - w0, 1);
				check_eq("awaddr_o", last_awaddr, addr);
				check_eq("wdata_o", last_wdata, wdata);
				check_eq("wstrb_o", last_wstrb, 4'hf);
			end else begin
				check_eq("aw handshakes", aw_count - aw0, 0);
			end
		end
	endtask

	// --------------------------------------------------
	// random traffic
	// --------------------------------------------------
	task automatic inst_random(input logic strict, input logic odd);
		mem_types_pkg::byte_addr_t addr;
		addr = 16'(($urandom % 64) * 4);
		if (odd && ($urandom % 8 == 0))
			addr[1:0] = 2'(1 + $urandom % 3);
		access(1'b0, 1'b0, addr, '0, strict);
	endtask

	// data side stays above the instruction quarter
	task automatic data_random(input logic strict, input logic odd);
		mem_types_pkg::byte_addr_t addr;
		logic                      we;
		int                        pick;
		pick = $urandom % 16;
		we   = 1'($urandom % 2);
		addr = 16'h4000 | 16'(($urandom % 48) * 4);
		if (odd && pick == 0)
			addr[15] = 1'b1;
		if (odd && pick == 1)
			addr[1:0] = 2'(1 + $urandom % 3);
		access(1'b1, we, addr, $urandom, strict);
	endtask

	initial begin
		int n0;
		void'($urandom(87077));
		drive_port(1'b0, 1'b0, 1'b0, '0, '0);
		drive_port(1'b1, 1'b0, 1'b0, '0, '0);
		for (int i = 0; i < 2 ** mem_types_pkg::WORD_ADDR_W; i++)
			ref_mem[i] = {2'b10, 14'(i), 2'b01, 14'(i)};
		for (int i = 0; i < LINES; i++) begin
			line_valid[0][i] = 1'b0;
			line_valid[1][i] = 1'b0;
		end
		reset_i = 1'b0;
		repeat (3) @(posedge clock_cntrl_i);
		@(negedge clock_cntrl_i);
		reset_i = 1'b1;

		// quiet outputs straight out of reset
		check_eq("inst_done_o", inst_done_o, 0);
		check_eq("data_done_o", data_done_o, 0);
		check_eq("awvalid_o", awvalid_o, 0);
		check_eq("wvalid_o", wvalid_o, 0);
		check_eq("arvalid_o", arvalid_o, 0);
		check_eq("bready_o", bready_o, 0);
		check_eq("rready_o", rready_o, 0);
		check_eq("exceptions_o", exceptions_o, 0);

		repeat (200) data_random(1'b1, 1'b0);
		repeat (100) inst_random(1'b1, 1'b0);

		// aligned traffic inside the good range raises no exception
		check_eq("exceptions_o", exceptions_o, 0);

		// misaligned on both ports and then bus errors
		access(1'b0, 1'b0, 16'h0006, '0, 1'b1);
		access(1'b1, 1'b1, 16'h4001, 32'h1234_5678, 1'b1);
		access(1'b1, 1'b0, 16'h4003, '0, 1'b1);
		access(1'b1, 1'b0, 16'h8010, '0, 1'b1);
		access(1'b1, 1'b0, 16'h8010, '0, 1'b1);
		access(1'b1, 1'b1, 16'h8020, 32'hdead_beef, 1'b1);

		// both miss together and the instruction read goes out first
		n0 = ar_log.size();
		fork
			access(1'b0, 1'b0, 16'h2000, '0, 1'b0);
			access(1'b1, 1'b0, 16'h7000, '0, 1'b0);
		join
		check_eq("ar handshakes", ar_log.size() - n0, 2);
		if (ar_log.size() >= n0 + 2) begin
			check_eq("first araddr_o", ar_log[n0], 16'h2000);
			check_eq("second araddr_o", ar_log[n0 + 1], 16'h7000);
		end

		fork
			repeat (150) inst_random(1'b0, 1'b1);
			repeat (150) data_random(1'b0, 1'b1);
		join
		finish_run();
	end

endmodule

// File: sim.f
src/mem_types_pkg.sv
src/mem_ctrl_pkg.sv
src/mem_link_if.sv
src/l1_word_cache.sv
src/access_arbiter.sv
src/axi_lite_master.sv
src/mem_subsystem_top.sv
tb/axi_lite_mem_model.sv
tb/tb_mem_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem -f sim.f \
	-o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
